/* Makefile */
VERILATOR = verilator
FLAGS     = --binary --assert -Wno-fatal
TOP       = fpuTb
FLIST     = flist.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = CHECKS FAILED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* common/fpuPkg.sv */
// Shared FPU types
// Opcode enum and operand-kind enum

package fpuPkg;

        // Decoded operations, arithmetic and unknown words fall to OP_NONE
        typedef enum logic [3:0] {
                OP_NONE,
                // Sign injection
                OP_FSGNJ,
                OP_FSGNJN,
                OP_FSGNJX,
                // Raw moves between register files
                OP_FMVXW,
                OP_FMVWX,
                // Int to float
                OP_FCVTSW,
                OP_FCVTSWU,
                // Float to int
                OP_FCVTWS,
                OP_FCVTWUS,
                // Compares
                OP_FEQ,
                OP_FLT,
                OP_FLE,
                OP_FMIN,
                OP_FMAX,
                OP_FCLASS
        } fpuOp_e;

        // Operand category from the classifier
        typedef enum logic [2:0] {
                KIND_ZERO,
                KIND_SUB,
                KIND_NORM,
                KIND_INF,
                KIND_SNAN,
                KIND_QNAN
        } fKind_e;

endpackage

/* common/fpu_defs.svh */
// Width and constant macros for the single-precision FPU datapath
// Operand, exponent, significand and class-mask sizes

`ifndef FPU_DEFS_SVH
`define FPU_DEFS_SVH

// Operand and result word
`define FLEN 32

// Signed exponent after the bias is removed
`define EXP_W 10

// Significand with the hidden bit in front
`define SIG_W 24

// One bit per fclass category
`define CLASS_W 10

`define CANON_NAN 32'h7fc00000

`endif

/* design/fClass.sv */
// Single-precision operand unpacker
// Sign, unbiased exponent, significand, kind and fclass mask

`include "fpu_defs.svh"

module fClass
        import fpuPkg::*;
(
        input  logic [`FLEN-1:0]           operand_i,
        output logic                       sign_o,
        output logic signed [`EXP_W-1:0]   exp_o,
        output logic [`SIG_W-1:0]          sig_o,
        output fKind_e                     kind_o,
        output logic [`CLASS_W-1:0]        classMask_o
);

        localparam logic signed [`EXP_W-1:0] ExpBias = 127;

        logic [7:0]         expField;
        logic [`SIG_W-2:0]  frac;
        logic               expZero;
        logic               expOnes;

        assign sign_o   = operand_i[`FLEN-1];
        assign expField = operand_i[30:23];
        assign frac     = operand_i[22:0];
        assign expZero  = (expField == 8'h00);
        assign expOnes  = (expField == 8'hff);

        // Subnormals sit at the minimum exponent, -126
        assign exp_o = expZero ? (1 - ExpBias)
                               : ($signed({{(`EXP_W-8){1'b0}}, expField}) - ExpBias);
        assign sig_o = {~expZero, frac};

        always_comb begin
                if (expZero)
                        kind_o = (frac == '0) ? KIND_ZERO : KIND_SUB;
                else if (expOnes)
                        kind_o = (frac == '0) ? KIND_INF : (frac[22] ? KIND_QNAN : KIND_SNAN);
                else
                        kind_o = KIND_NORM;
        end

        // One-hot RISC-V class mask, negative categories in the low bits
        always_comb begin
                classMask_o = '0;
                case (kind_o)
                        KIND_INF:  classMask_o[sign_o ? 0 : 7] = 1'b1;
                        KIND_NORM: classMask_o[sign_o ? 1 : 6] = 1'b1;
                        KIND_SUB:  classMask_o[sign_o ? 2 : 5] = 1'b1;
                        KIND_ZERO: classMask_o[sign_o ? 3 : 4] = 1'b1;
                        KIND_SNAN: classMask_o[8] = 1'b1;
                        default:   classMask_o[9] = 1'b1;
                endcase
        end

endmodule

/* design/fCompare.sv */
// Floating-point comparator for FEQ, FLT and FLE
// NaN clears every result, signed zeros compare equal

`include "fpu_defs.svh"

module fCompare
        import fpuPkg::*;
(
        input  logic                       aSign_i,
        input  logic signed [`EXP_W-1:0]   aExp_i,
        input  logic [`SIG_W-1:0]          aSig_i,
        input  fKind_e                     aKind_i,
        input  logic                       bSign_i,
        input  logic signed [`EXP_W-1:0]   bExp_i,
        input  logic [`SIG_W-1:0]          bSig_i,
        input  fKind_e                     bKind_i,
        output logic                       eq_o,
        output logic                       lt_o,
        output logic                       le_o
);

        logic anyNan;
        logic bothZero;
        logic magEq;
        logic magLt;
        logic ordLt;

        assign anyNan   = (aKind_i == KIND_SNAN) || (aKind_i == KIND_QNAN) ||
                          (bKind_i == KIND_SNAN) || (bKind_i == KIND_QNAN);
        assign bothZero = (aKind_i == KIND_ZERO) && (bKind_i == KIND_ZERO);

        // Infinity unpacks to exponent 128, above every finite value
        assign magEq = (aExp_i == bExp_i) && (aSig_i == bSig_i);
        assign magLt = (aExp_i < bExp_i) || ((aExp_i == bExp_i) && (aSig_i < bSig_i));

        always_comb begin
                if (bothZero)
                        ordLt = 1'b0;
                else if (aSign_i != bSign_i)
                        // Negative side is always the smaller one
                        ordLt = aSign_i;
                else if (!aSign_i)
                        ordLt = magLt;
                else
                        // Both negative so the larger magnitude is smaller
                        ordLt = ~magLt & ~magEq;
        end

        always_comb begin
                if (anyNan) begin
                        eq_o = 1'b0;
                        lt_o = 1'b0;
                end else begin
                        eq_o = bothZero || ((aSign_i == bSign_i) && magEq);
                        lt_o = ordLt;
                end
        end

        assign le_o = eq_o | lt_o;

endmodule

/* design/fConvert.sv */
// Integer and single-precision conversions
// Both directions truncate toward zero, float to int saturates

`include "fpu_defs.svh"

module fConvert
        import fpuPkg::*;
(
        input  fpuOp_e                     op_i,
        input  logic [`FLEN-1:0]           operand_i,
        input  logic                       sign_i,
        input  logic signed [`EXP_W-1:0]   exp_i,
        input  logic [`SIG_W-1:0]          sig_i,
        input  fKind_e                     kind_i,
        output logic [`FLEN-1:0]           cvtOut_o
);

        localparam int WideW = `FLEN + `SIG_W;

        // Int to float path
        logic                   intNeg;
        logic [`FLEN-1:0]       intMag;
        logic [4:0]             lead;
        logic [`FLEN-1:0]       norm;
        logic [7:0]             biasedExp;
        logic [`FLEN-1:0]       i2fOut;

        // Float to int path
        logic                   isNan;
        logic [WideW-1:0]       wide;
        logic [`FLEN-1:0]       truncMag;
        logic [`FLEN-1:0]       wsOut;
        logic [`FLEN-1:0]       wusOut;

        assign intNeg = (op_i == OP_FCVTSW) && operand_i[`FLEN-1];
        assign intMag = intNeg ? -operand_i : operand_i;

        // Position of the highest set bit
        always_comb begin
                lead = '0;
                for (int i = 0; i < `FLEN; i++) begin
                        if (intMag[i])
                                lead = 5'(i);
                end
        end

        assign norm      = intMag << (5'd31 - lead);
        assign biasedExp = 8'd127 + {3'b000, lead};
        // Bits below the 23-bit fraction are simply dropped
        assign i2fOut    = (intMag == '0) ? '0 : {intNeg, biasedExp, norm[30:8]};

        assign isNan    = (kind_i == KIND_SNAN) || (kind_i == KIND_QNAN);
        assign wide     = {{(WideW-`SIG_W){1'b0}}, sig_i} << exp_i[4:0];
        assign truncMag = wide[WideW-2:`SIG_W-1];

        always_comb begin
                if (isNan)
                        wsOut = 32'h7fffffff;
                else if (exp_i < 0)
                        wsOut = '0;
                else if (exp_i >= 31)
                        // Covers infinities and -2^31 exactly
                        wsOut = sign_i ? 32'h80000000 : 32'h7fffffff;
                else
                        wsOut = sign_i ? -truncMag : truncMag;
        end

        always_comb begin
                if (isNan)
                        wusOut = 32'hffffffff;
                else if (sign_i || (exp_i < 0))
                        wusOut = '0;
                else if (exp_i >= 32)
                        wusOut = 32'hffffffff;
                else
                        wusOut = truncMag;
        end

        always_comb begin
                case (op_i)
                        OP_FCVTSW, OP_FCVTSWU: cvtOut_o = i2fOut;
                        OP_FCVTWS:             cvtOut_o = wsOut;
                        OP_FCVTWUS:            cvtOut_o = wusOut;
                        default:               cvtOut_o = '0;
                endcase
        end

endmodule

/* design/fpu.sv */
// FPU top level
// Decoder, two classifiers, comparator, converter and result register

`include "fpu_defs.svh"

module fpu
        import fpuPkg::*;
(
        input  logic             clk_i,
        input  logic             rst_i,
        input  logic             fpuEnable_i,
        input  logic [31:0]      instr_i,
        input  logic [`FLEN-1:0] rs1_i,
        input  logic [`FLEN-1:0] rs2_i,
        output logic [`FLEN-1:0] fpuOut_o,
        output logic             fpuValid_o
);

        fpuOp_e                     op;
        logic                       rs1Sign, rs2Sign;
        logic signed [`EXP_W-1:0]   rs1Exp, rs2Exp;
        logic [`SIG_W-1:0]          rs1Sig, rs2Sig;
        fKind_e                     rs1Kind, rs2Kind;
        logic [`CLASS_W-1:0]        rs1Mask;
        logic                       rs1Nan, rs2Nan;
        logic                       cmpEq, cmpLt, cmpLe;
        logic [`FLEN-1:0]           cvtOut;

        assign rs1Nan = (rs1Kind == KIND_SNAN) || (rs1Kind == KIND_QNAN);
        assign rs2Nan = (rs2Kind == KIND_SNAN) || (rs2Kind == KIND_QNAN);

        fpuDecode decode (.instr_i(instr_i), .op_o(op));

        fClass class1 (.operand_i(rs1_i), .sign_o(rs1Sign), .exp_o(rs1Exp),
                .sig_o(rs1Sig), .kind_o(rs1Kind), .classMask_o(rs1Mask));
        // rs2 mask is not needed
        fClass class2 (.operand_i(rs2_i), .sign_o(rs2Sign), .exp_o(rs2Exp),
                .sig_o(rs2Sig), .kind_o(rs2Kind), .classMask_o());

        fCompare compare (.aSign_i(rs1Sign), .aExp_i(rs1Exp), .aSig_i(rs1Sig),
                .aKind_i(rs1Kind), .bSign_i(rs2Sign), .bExp_i(rs2Exp), .bSig_i(rs2Sig),
                .bKind_i(rs2Kind), .eq_o(cmpEq), .lt_o(cmpLt), .le_o(cmpLe));

        fConvert convert (.op_i(op), .operand_i(rs1_i), .sign_i(rs1Sign), .exp_i(rs1Exp),
                .sig_i(rs1Sig), .kind_i(rs1Kind), .cvtOut_o(cvtOut));

        fpuResult result (.clk_i(clk_i), .rst_i(rst_i), .enable_i(fpuEnable_i), .op_i(op),
                .rs1_i(rs1_i), .rs2_i(rs2_i), .rs1Mask_i(rs1Mask), .rs1Nan_i(rs1Nan),
                .rs2Nan_i(rs2Nan), .eq_i(cmpEq), .lt_i(cmpLt), .le_i(cmpLe),
                .cvt_i(cvtOut), .result_o(fpuOut_o), .valid_o(fpuValid_o));

endmodule

/* design/fpuDecode.sv */
// RV32F instruction decoder
// Maps funct5, rm and rs2 bit 20 onto an opcode

module fpuDecode
        import fpuPkg::*;
(
        input  logic [31:0] instr_i,
        output fpuOp_e      op_o
);

        logic [4:0] funct5;
        logic [1:0] rmLow;
        logic       isFma;

        assign funct5 = instr_i[31:27];
        assign rmLow  = instr_i[13:12];
        // Fused multiply-add opcodes have bit 4 clear
        assign isFma  = ~instr_i[4];

        always_comb begin
                op_o = OP_NONE;
                if (!isFma) begin
                        case (funct5)
                                5'b00100: begin
                                        case (rmLow)
                                                2'b00:   op_o = OP_FSGNJ;
                                                2'b01:   op_o = OP_FSGNJN;
                                                2'b10:   op_o = OP_FSGNJX;
                                                default: op_o = OP_NONE;
                                        endcase
                                end
                                // Min when rm bit 12 is low
                                5'b00101: op_o = instr_i[12] ? OP_FMAX : OP_FMIN;
                                5'b10100: begin
                                        case (rmLow)
                                                2'b10:   op_o = OP_FEQ;
                                                2'b01:   op_o = OP_FLT;
                                                2'b00:   op_o = OP_FLE;
                                                default: op_o = OP_NONE;
                                        endcase
                                end
                                // FCLASS and FMV.X.W share funct5
                                5'b11100: op_o = instr_i[12] ? OP_FCLASS : OP_FMVXW;
                                // Bit 20 picks the unsigned form
                                5'b11000: op_o = instr_i[20] ? OP_FCVTWUS : OP_FCVTWS;
                                5'b11010: op_o = instr_i[20] ? OP_FCVTSWU : OP_FCVTSW;
                                5'b11110: op_o = OP_FMVWX;
                                // Add, sub, mul, div, sqrt and the rest
                                default:  op_o = OP_NONE;
                        endcase
                end
        end

endmodule

/* design/fpuResult.sv */
// Result select per opcode and the output register
// Holds the min/max NaN rules and the valid pulse

`include "fpu_defs.svh"

module fpuResult
        import fpuPkg::*;
(
        input  logic                clk_i,
        input  logic                rst_i,
        input  logic                enable_i,
        input  fpuOp_e              op_i,
        input  logic [`FLEN-1:0]    rs1_i,
        input  logic [`FLEN-1:0]    rs2_i,
        input  logic [`CLASS_W-1:0] rs1Mask_i,
        input  logic                rs1Nan_i,
        input  logic                rs2Nan_i,
        input  logic                eq_i,
        input  logic                lt_i,
        input  logic                le_i,
        input  logic [`FLEN-1:0]    cvt_i,
        output logic [`FLEN-1:0]    result_o,
        output logic                valid_o
);

        logic                isMax;
        logic [`FLEN-1:0]    minMax;
        logic [`FLEN-1:0]    nextResult;

        assign isMax = (op_i == OP_FMAX);

        always_comb begin
                if (rs1Nan_i && rs2Nan_i)
                        minMax = `CANON_NAN;
                else if (rs1Nan_i)
                        minMax = rs2_i;
                else if (rs2Nan_i)
                        minMax = rs1_i;
                else if (eq_i)
                        // Only +0 and -0 differ here, min wants the negative one
                        minMax = (rs1_i[`FLEN-1] ^ isMax) ? rs1_i : rs2_i;
                else
                        minMax = (lt_i ^ isMax) ? rs1_i : rs2_i;
        end

        always_comb begin
                case (op_i)
                        OP_FSGNJ:   nextResult = {rs2_i[31], rs1_i[30:0]};
                        OP_FSGNJN:  nextResult = {~rs2_i[31], rs1_i[30:0]};
                        OP_FSGNJX:  nextResult = {rs1_i[31] ^ rs2_i[31], rs1_i[30:0]};
                        OP_FMVXW,
                        OP_FMVWX:   nextResult = rs1_i;
                        OP_FCVTSW,
                        OP_FCVTSWU,
                        OP_FCVTWS,
                        OP_FCVTWUS: nextResult = cvt_i;
                        OP_FEQ:     nextResult = {{(`FLEN-1){1'b0}}, eq_i};
                        OP_FLT:     nextResult = {{(`FLEN-1){1'b0}}, lt_i};
                        OP_FLE:     nextResult = {{(`FLEN-1){1'b0}}, le_i};
                        OP_FMIN,
                        OP_FMAX:    nextResult = minMax;
                        OP_FCLASS:  nextResult = {{(`FLEN-`CLASS_W){1'b0}}, rs1Mask_i};
                        default:    nextResult = '0;
                endcase
        end

        // Output holds between enables
        always_ff @(posedge clk_i) begin
                if (rst_i) begin
                        result_o <= '0;
                        valid_o  <= 1'b0;
                end else begin
                        valid_o <= enable_i;
                        if (enable_i)
                                result_o <= nextResult;
                end
        end

endmodule

/* flist.f */
+incdir+common
common/fpuPkg.sv
design/fpuDecode.sv
design/fClass.sv
design/fCompare.sv
design/fConvert.sv
design/fpuResult.sv
design/fpu.sv
verif/fpu_properties.sv
verif/fpuTb.sv

/* verif/fpuTb.sv */
// FPU testbench with directed and LCG stimulus
// Reference model, result checker and cycle watchdog

`include "fpu_defs.svh"

module fpuTb;

        localparam int NumOps     = 23;
        localparam int NumSpec    = 22;
        localparam int NumRand    = 3000;
        localparam int NumTests   = NumOps * NumSpec * NumSpec + NumRand;
        localparam int CycleLimit = 2 * NumTests + 50;

        logic        clk_i, rst_i, fpuEnable_i, fpuValid_o;
        logic [31:0] instr_i, rs1_i, rs2_i, fpuOut_o;
        logic [31:0] expQ[$], instrQ[$];
        logic [31:0] seed, a, b, popExp, popInstr;
        logic [31:0] lastOut = '0;
        int          errors = 0, issued = 0, pulses = 0, cycles = 0;

        // OP-FP word with rs1 = 1, rd = 2 and the given rs2 field
        function automatic logic [31:0] opFp(input logic [4:0] f5, input logic [4:0] rs2f,
                                              input logic [2:0] rm);
                return {f5, 2'b00, rs2f, 5'd1, rm, 5'd2, 7'b1010011};
        endfunction

        // Zeros, infinities, NaNs, subnormals, integer range edges
        logic [31:0] specials [NumSpec] = '{
                32'h00000000, 32'h80000000, 32'h7f800000, 32'hff800000, 32'h7fc00000,
                32'h7fa00000, 32'hffc00001, 32'h00000001, 32'h807fffff, 32'h3f800000,
                32'hbf800000, 32'h3f000000, 32'hbf400000, 32'h4f000000, 32'hcf000000,
                32'h4f800000, 32'h4effffff, 32'h7fffffff, 32'hffffffff, 32'h01ffffff,
                32'h40490fdb, 32'hc2f6e979};

        // Every decoded op, then arithmetic, unknown words and FMADD
        logic [31:0] opList [NumOps] = '{
                opFp(5'b00100, 5'd0, 3'd0), opFp(5'b00100, 5'd0, 3'd1), opFp(5'b00100, 5'd0, 3'd2),
                opFp(5'b00101, 5'd0, 3'd0), opFp(5'b00101, 5'd0, 3'd1), opFp(5'b10100, 5'd0, 3'd2),
                opFp(5'b10100, 5'd0, 3'd1), opFp(5'b10100, 5'd0, 3'd0), opFp(5'b11100, 5'd0, 3'd1),
                opFp(5'b11100, 5'd0, 3'd0), opFp(5'b11110, 5'd0, 3'd0), opFp(5'b11000, 5'd0, 3'd1),
                opFp(5'b11000, 5'd1, 3'd1), opFp(5'b11010, 5'd0, 3'd1), opFp(5'b11010, 5'd1, 3'd1),
                opFp(5'b00000, 5'd0, 3'd0), opFp(5'b00001, 5'd0, 3'd0), opFp(5'b00010, 5'd0, 3'd0),
                opFp(5'b00011, 5'd0, 3'd0), opFp(5'b01011, 5'd0, 3'd0), opFp(5'b10100, 5'd0, 3'd3),
                opFp(5'b00100, 5'd0, 3'd3), 32'h00208143};

        fpu dut (.*);

        function automatic logic [31:0] lcgNext(input logic [31:0] s);
                return s * 32'd1664525 + 32'd1013904223;
        endfunction

        function automatic logic isNan(input logic [31:0] x);
                return (x[30:23] == 8'hff) && (x[22:0] != '0);
        endfunction

        // Sign-magnitude mapped onto a signed line, both zeros at 0
        function automatic longint orderKey(input logic [31:0] x);
                longint mag;
                mag = longint'(x[30:0]);
                return x[31] ? -mag : mag;
        endfunction

        function automatic logic [31:0] classMask(input logic [31:0] x);
                int idx;
                if (x[30:23] == 8'hff)
                        idx = (x[22:0] == '0) ? (x[31] ? 0 : 7) : (x[22] ? 9 : 8);
                else if (x[30:23] == 8'h00)
                        idx = (x[22:0] == '0) ? (x[31] ? 3 : 4) : (x[31] ? 2 : 5);
                else
                        idx = x[31] ? 1 : 6;
                return 32'd1 << idx;
        endfunction

        function automatic logic [31:0] toFloat(input logic [31:0] x, input logic sgn);
                logic        neg;
                logic [31:0] mag;
                int          e;
                neg = sgn && x[31];
                mag = neg ? -x : x;
                // Biased exponent with the leading one at bit 31
                e   = 158;
                if (mag == '0)
                        return '0;
                while (!mag[31]) begin
                        mag = mag << 1;
                        e--;
                end
                return {neg, e[7:0], mag[30:8]};
        endfunction

        function automatic logic [31:0] toInt(input logic [31:0] x, input logic sgn);
                int          e;
                logic [63:0] wide;
                logic [31:0] mag;
                e    = int'(x[30:23]) - 127;
                wide = {40'd0, 1'b1, x[22:0]};
                wide = (e >= 23) ? (wide << (e - 23)) : (wide >> (23 - e));
                mag  = wide[31:0];
                if (isNan(x))
                        return sgn ? 32'h7fffffff : 32'hffffffff;
                if (sgn)
                        return (e >= 31) ? (x[31] ? 32'h80000000 : 32'h7fffffff)
                                         : (x[31] ? -mag : mag);
                if (x[31])
                        return '0;
                return (e >= 32) ? 32'hffffffff : mag;
        endfunction

        // Expected result from the instruction fields and both operands
        function automatic logic [31:0] fpuRef(input logic [31:0] instr, input logic [31:0] x,
                                                input logic [31:0] y);
                logic   nanX, nanY, isMax, takeX;
                longint kx, ky;
                nanX  = isNan(x);
                nanY  = isNan(y);
                kx    = orderKey(x);
                ky    = orderKey(y);
                isMax = instr[12];
                if (instr[6:0] != 7'b1010011)
                        return '0;
                case ({instr[31:27], instr[14:12]})
                        {5'b00100, 3'd0}: return {y[31], x[30:0]};
                        {5'b00100, 3'd1}: return {~y[31], x[30:0]};
                        {5'b00100, 3'd2}: return {x[31] ^ y[31], x[30:0]};
                        {5'b00101, 3'd0}, {5'b00101, 3'd1}: begin
                                if (nanX && nanY)
                                        return `CANON_NAN;
                                if (nanX || nanY)
                                        return nanX ? y : x;
                                // Equal keys with different bits means signed zeros
                                if (kx == ky)
                                        takeX = isMax ? !x[31] : x[31];
                                else
                                        takeX = isMax ? (kx > ky) : (kx < ky);
                                return takeX ? x : y;
                        end
                        {5'b10100, 3'd2}: return 32'(!nanX && !nanY && (kx == ky));
                        {5'b10100, 3'd1}: return 32'(!nanX && !nanY && (kx < ky));
                        {5'b10100, 3'd0}: return 32'(!nanX && !nanY && (kx <= ky));
                        {5'b11100, 3'd0}, {5'b11110, 3'd0}: return x;
                        {5'b11100, 3'd1}: return classMask(x);
                        {5'b11000, 3'd1}: return toInt(x, !instr[20]);
                        {5'b11010, 3'd1}: return toFloat(x, !instr[20]);
                        default:          return '0;
                endcase
        endfunction

        task automatic checkValue(input string name, input logic [31:0] expected,
                                  input logic [31:0] actual);
                if (expected !== actual) begin
                        errors++;
                        $display("FAILED %s: expected %h, got %h", name, expected, actual);
                end
        endtask

        task automatic issueOp(input logic [31:0] instr, input logic [31:0] x,
                               input logic [31:0] y);
                @(posedge clk_i);
                fpuEnable_i <= 1'b1;
                instr_i     <= instr;
                rs1_i       <= x;
                rs2_i       <= y;
                expQ.push_back(fpuRef(instr, x, y));
                instrQ.push_back(instr);
                issued++;
                // Idle gap now and then, the rest run back to back
                if (issued % 5 == 0) begin
                        @(posedge clk_i);
                        fpuEnable_i <= 1'b0;
                end
        endtask

        initial begin
                clk_i = 1'b0;
                forever #4 clk_i = ~clk_i;
        end

        // Compare on the falling edge where outputs are settled
        always @(negedge clk_i) begin
                if (!rst_i && fpuValid_o) begin
                        pulses++;
                        if (expQ.size() == 0) begin
                                errors++;
                                $display("Result valid pulse arrived with no instruction outstanding");
                        end else begin
                                popExp   = expQ.pop_front();
                                popInstr = instrQ.pop_front();
                                checkValue($sformatf("fpuOut_o for instr %h", popInstr), popExp,
                                           fpuOut_o);
                        end
                        lastOut = fpuOut_o;
                end else if (!rst_i) begin
                        checkValue("fpuOut_o while idle", lastOut, fpuOut_o);
                end
        end

        initial begin
                while (cycles < CycleLimit) begin
                        @(posedge clk_i);
                        cycles++;
                end
                $display("Timeout after %0d cycles with %0d results outstanding", cycles,
                         expQ.size());
                $display("CHECKS FAILED");
                $finish;
        end

        initial begin
                rst_i       = 1'b1;
                fpuEnable_i = 1'b0;
                instr_i     = '0;
                rs1_i       = '0;
                rs2_i       = '0;
                seed        = 32'hdc5d8c12;
                repeat (4) @(posedge clk_i);
                rst_i <= 1'b0;
                @(negedge clk_i);
                checkValue("fpuOut_o after reset", '0, fpuOut_o);
                checkValue("fpuValid_o after reset", '0, 32'(fpuValid_o));
                foreach (opList[o])
                        foreach (specials[i])
                                foreach (specials[j])
                                        issueOp(opList[o], specials[i], specials[j]);
                for (int r = 0; r < NumRand; r++) begin
                        a    = lcgNext(seed);
                        b    = lcgNext(a);
                        seed = lcgNext(b);
                        issueOp(opList[int'(seed[31:16]) % NumOps], a, b);
                end
                @(posedge clk_i);
                fpuEnable_i <= 1'b0;
                while (expQ.size() != 0)
                        @(negedge clk_i);
                @(negedge clk_i);
                checkValue("valid pulse count", 32'(issued), 32'(pulses));
                // Failures of the bound assertions count as errors too
                errors += dut.props.assertFails;
                $display("Errors: %0d", errors);
                if (errors == 0)
                        $display("ALL CHECKS PASSED");
                else
                        $display("CHECKS FAILED");
                $finish;
        end

endmodule

/* verif/fpu_properties.sv */
// Concurrent assertions on the FPU valid pulse and reset state
// Bound onto the fpu top level

`include "fpu_defs.svh"

module fpuProperties (
        input logic             clk_i,
        input logic             rst_i,
        input logic             fpuEnable_i,
        input logic             fpuValid_o,
        input logic [`FLEN-1:0] fpuOut_o
);

        // Number of assertion failures so far
        int assertFails = 0;

        // One result per enable, one cycle later
        validAfterEnable: assert property (@(posedge clk_i) disable iff (rst_i)
                fpuEnable_i |=> fpuValid_o)
                else begin
                        assertFails++;
                        $error("fpuValid_o missing one cycle after fpuEnable_i");
                end

        validOnlyAfterEnable: assert property (@(posedge clk_i) disable iff (rst_i)
                !fpuEnable_i |=> !fpuValid_o)
                else begin
                        assertFails++;
                        $error("fpuValid_o high without an enable in the previous cycle");
                end

        // Output register cleared by reset
        resetClears: assert property (@(posedge clk_i)
                rst_i |=> (!fpuValid_o && (fpuOut_o == '0)))
                else begin
                        assertFails++;
                        $error("fpuValid_o or fpuOut_o not cleared after reset");
                end

endmodule

bind fpu fpuProperties props (.clk_i(clk_i), .rst_i(rst_i), .fpuEnable_i(fpuEnable_i),
        .fpuValid_o(fpuValid_o), .fpuOut_o(fpuOut_o));
